/* verilog.f */
+incdir+testbench
verilog/core_pkg.sv
verilog/reg_file_nwnr.sv
verilog/issue_ctrl.sv
verilog/alu_stage.sv
verilog/result_stage.sv
verilog/exec_core.sv
testbench/tb_exec_core.sv

/* run_sim.sh */
#!/bin/sh
# build and run the exec_core testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 \
   -f verilog.f \
   --top-module tb_exec_core \
   --Mdir obj_dir \
   -o tb_exec_core
status=$?
if [ $status -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit $status
fi

./obj_dir/tb_exec_core
status=$?
if [ $status -ne 0 ]; then
   echo "simulation failed with status $status"
   exit $status
fi

exit 0

/* testbench/tb_model.svh */
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

word_t     model_regs [NUM_REGS];                      // register view in acceptance order
reg_addr_t exp_rd_q [$];                               // expected destinations, oldest first
word_t     exp_data_q [$];                             // expected results, same order

// register r resets to byte r in all four lanes
function automatic word_t reset_value(input int r);
   return word_t'(r) * 32'h0101_0101;
endfunction

function automatic word_t alu_model(input alu_op_t op, input word_t a, input word_t b,
                                    input imm_t imm);
   word_t sext;
   sext = word_t'(int'(imm));                          // int cast carries the sign
   case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      OP_OR:   return a | b;
      OP_XOR:  return a ^ b;
      OP_SLL:  return a << b[4:0];                     // only five shift bits count
      OP_SRL:  return a >> b[4:0];
      OP_ADDI: return a + sext;
      default: return '0;
   endcase
endfunction

task automatic model_reset();
   for (int i = 0; i < NUM_REGS; i++) begin
      model_regs[i] = reset_value(i);
   end
   exp_rd_q.delete();
   exp_data_q.delete();
endtask

// operands come from the view before this instruction writes rd
task automatic model_accept(input alu_op_t op, input reg_addr_t rd, input reg_addr_t rs1,
                            input reg_addr_t rs2, input imm_t imm);
   word_t v;
   v = alu_model(op, model_regs[rs1], model_regs[rs2], imm);
   model_regs[rd] = v;
   exp_rd_q.push_back(rd);
   exp_data_q.push_back(v);
endtask

`endif

/* testbench/tb_exec_core.sv */
`timescale 1ns/1ns

module tb_exec_core;
   import core_pkg::*;

   localparam int PERIOD       = 100;                  // ns
   localparam int SETTLE       = 40;                   // sample point after the falling edge
   localparam int LAT_RUNS     = 4;
   localparam int SHIFT_RUNS   = 20;
   localparam int NUM_RANDOM   = 400;
   localparam int NUM_INSTR    = 2*NUM_REGS + LAT_RUNS + SHIFT_RUNS + NUM_RANDOM;
   localparam int LIMIT_CYCLES = NUM_INSTR*40 + 500;   // generous per instruction

   logic      CLK;
   logic      RST;
   logic      in_valid;
   logic      in_ready;
   alu_op_t   in_op;
   reg_addr_t in_rd;
   reg_addr_t in_rs1;
   reg_addr_t in_rs2;
   imm_t      in_imm;
   logic      res_valid;
   logic      res_ready;
   reg_addr_t res_rd;
   word_t     res_data;
   logic      host_we;
   reg_addr_t host_addr;
   word_t     host_data;

   bit        rdy_hold;                                // 1 = res_ready stuck high
   int        acc_count;                               // instructions accepted
   int        res_count;                               // results taken
   bit        held;                                    // result was stalled last sample
   reg_addr_t held_rd;
   word_t     held_data;

   `include "tb_model.svh"

   exec_core exec_core_i (
      .CLK       (CLK),
      .RST       (RST),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .in_op     (in_op),
      .in_rd     (in_rd),
      .in_rs1    (in_rs1),
      .in_rs2    (in_rs2),
      .in_imm    (in_imm),
      .res_valid (res_valid),
      .res_ready (res_ready),
      .res_rd    (res_rd),
      .res_data  (res_data),
      .host_we   (host_we),
      .host_addr (host_addr),
      .host_data (host_data)
   );

   task automatic check_word(input string name, input word_t got, input word_t exp);
      if (got !== exp) begin
         $display("ERR %0t ns %s got %h expected %h", $time, name, got, exp);
         $display("TEST FAILED");
         $fatal(1, "data mismatch");
      end
   endtask

   task automatic check_addr(input string name, input reg_addr_t got, input reg_addr_t exp);
      if (got !== exp) begin
         $display("ERR %0t ns %s got %0d expected %0d", $time, name, got, exp);
         $display("TEST FAILED");
         $fatal(1, "register number mismatch");
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("ERR %0t ns %s got %b expected %b", $time, name, got, exp);
         $display("TEST FAILED");
         $fatal(1, "handshake mismatch");
      end
   endtask

   // called at a falling edge, returns at the falling edge after the accept edge
   task automatic send_instr(input alu_op_t op, input reg_addr_t rd, input reg_addr_t rs1,
                             input reg_addr_t rs2, input imm_t imm);
      bit taken;
      taken    = 1'b0;
      in_valid = 1'b1;
      in_op    = op;
      in_rd    = rd;
      in_rs1   = rs1;
      in_rs2   = rs2;
      in_imm   = imm;
      while (!taken) begin
         #SETTLE;
         if (in_ready) begin                           // handshake at the coming edge
            taken = 1'b1;
            model_accept(op, rd, rs1, rs2, imm);
            acc_count++;
         end
         @(negedge CLK);
      end
      in_valid = 1'b0;
   endtask

   task automatic host_write(input reg_addr_t a, input word_t d);
      host_we   = 1'b1;
      host_addr = a;
      host_data = d;
      model_regs[a] = d;
      @(negedge CLK);
      host_we = 1'b0;
   endtask

   // nothing in flight once every expected result has left
   task automatic wait_idle();
      while (exp_rd_q.size() != 0 || res_valid) begin
         @(negedge CLK);
      end
   endtask

   task automatic observe_result();
      reg_addr_t exp_rd;
      word_t     exp_data;
      if (held) begin                                  // stalled result must not move
         check_flag("res_valid", res_valid, 1'b1);
         check_addr("res_rd", res_rd, held_rd);
         check_word("res_data", res_data, held_data);
      end
      if (res_valid && res_ready) begin
         if (exp_rd_q.size() == 0) begin
            $display("a result for register %0d came out with no instruction pending",
                     res_rd);
            $display("TEST FAILED");
            $fatal(1, "unexpected result");
         end else begin
            exp_rd   = exp_rd_q.pop_front();
            exp_data = exp_data_q.pop_front();
            check_addr("res_rd", res_rd, exp_rd);
            check_word("res_data", res_data, exp_data);
            res_count++;
         end
      end
      held      = res_valid && !res_ready;
      held_rd   = res_rd;
      held_data = res_data;
   endtask

   initial begin
      CLK = 1'b0;
      forever #(PERIOD/2) CLK = ~CLK;
   end

   // res_ready changes only on the falling edge, about 70 percent high
   initial begin
      forever begin
         @(negedge CLK);
         res_ready = rdy_hold || ($urandom_range(0, 99) < 70);
      end
   end

   initial begin
      forever begin
         @(negedge CLK);
         #SETTLE;
         if (RST) begin
            observe_result();
         end
      end
   end

   initial begin
      #(LIMIT_CYCLES * PERIOD);
      $display("watchdog expired after %0d cycles, the run hung", LIMIT_CYCLES);
      $display("TEST FAILED");
      $fatal(1, "timeout");
   end

   initial begin
      alu_op_t   op;
      reg_addr_t rd;
      reg_addr_t rs1;
      reg_addr_t rs2;
      imm_t      imm;
      int        n;
      void'($urandom(32'hefef));                       // one seed for the whole run
      RST       = 1'b0;
      in_valid  = 1'b0;
      in_op     = OP_ADD;
      in_rd     = '0;
      in_rs1    = '0;
      in_rs2    = '0;
      in_imm    = '0;
      res_ready = 1'b0;
      host_we   = 1'b0;
      host_addr = '0;
      host_data = '0;
      rdy_hold  = 1'b0;
      acc_count = 0;
      res_count = 0;
      held      = 1'b0;
      held_rd   = '0;
      held_data = '0;
      model_reset();

      repeat (8) begin                                 // handshakes quiet in reset
         @(negedge CLK);
         check_flag("in_ready", in_ready, 1'b0);
         check_flag("res_valid", res_valid, 1'b0);
      end
      RST = 1'b1;

      for (n = 0; n < NUM_REGS; n++) begin             // reset contents via addi 0
         send_instr(OP_ADDI, reg_addr_t'(n), reg_addr_t'(n), reg_addr_t'(n), '0);
      end

      rdy_hold = 1'b1;                                 // latency with no stall
      @(negedge CLK);
      for (n = 0; n < LAT_RUNS; n++) begin
         wait_idle();
         send_instr(alu_op_t'($urandom_range(0, 7)), reg_addr_t'($urandom_range(0, 15)),
                    reg_addr_t'($urandom_range(0, 15)), reg_addr_t'($urandom_range(0, 15)),
                    imm_t'($urandom()));
         #SETTLE;
         check_flag("res_valid", res_valid, 1'b0);     // one cycle after the handshake
         @(negedge CLK);
         #SETTLE;
         check_flag("res_valid", res_valid, 1'b1);     // two cycles after
         @(negedge CLK);
      end
      rdy_hold = 1'b0;

      wait_idle();                                     // host preload, then read back
      for (n = 0; n < NUM_REGS; n++) begin
         host_write(reg_addr_t'(n), $urandom());
      end
      for (n = 0; n < NUM_REGS; n++) begin
         send_instr(OP_ADDI, reg_addr_t'(n), reg_addr_t'(n), reg_addr_t'(n), '0);
      end

      wait_idle();                                     // shift amounts 0, 31 and above 31
      host_write(4'd1, 32'd0);
      host_write(4'd2, 32'd31);
      host_write(4'd3, 32'd32);
      host_write(4'd4, 32'd37);
      host_write(4'd5, 32'hffff_ffe1);
      host_write(4'd8, $urandom());
      host_write(4'd9, 32'h8000_0001);
      for (n = 0; n < SHIFT_RUNS; n++) begin
         op  = (n % 2 == 0) ? OP_SLL : OP_SRL;
         rs1 = ((n / 2) % 2 == 0) ? 4'd8 : 4'd9;
         rs2 = reg_addr_t'(1 + (n / 4));
         send_instr(op, reg_addr_t'(10 + n % 6), rs1, rs2, '0);
      end

      for (n = 0; n < NUM_RANDOM; n++) begin           // mixed stream with dependencies
         op  = alu_op_t'($urandom_range(0, 7));
         rd  = reg_addr_t'($urandom_range(0, NUM_REGS-1));
         rs1 = reg_addr_t'($urandom_range(0, NUM_REGS-1));
         rs2 = reg_addr_t'($urandom_range(0, NUM_REGS-1));
         imm = imm_t'($urandom());
         send_instr(op, rd, rs1, rs2, imm);
         if ($urandom_range(0, 3) == 0) begin
            @(negedge CLK);                            // idle gap
         end
      end

      rdy_hold = 1'b1;                                 // drain, at most two in flight
      repeat (4) @(negedge CLK);
      if (res_count != acc_count) begin
         $display("%0d instructions accepted but %0d results returned", acc_count, res_count);
         $display("TEST FAILED");
         $fatal(1, "result count mismatch");
      end else begin
         $display("TEST PASSED");
         $finish;
      end
   end

endmodule

/* verilog/exec_core.sv */
`timescale 1ns/1ns

module exec_core (
   input  logic                CLK,
   input  logic                RST,
   // instruction port
   input  logic                in_valid,
   output logic                in_ready,
   input  core_pkg::alu_op_t   in_op,
   input  core_pkg::reg_addr_t in_rd,
   input  core_pkg::reg_addr_t in_rs1,
   input  core_pkg::reg_addr_t in_rs2,
   input  core_pkg::imm_t      in_imm,
   // result port
   output logic                res_valid,
   input  logic                res_ready,
   output core_pkg::reg_addr_t res_rd,
   output core_pkg::word_t     res_data,
   // host preload, rf write port 1
   input  logic                host_we,
   input  core_pkg::reg_addr_t host_addr,
   input  core_pkg::word_t     host_data
);
   import core_pkg::*;

   logic           accept;                               // also rf read enable
   logic           advance;
   word_t    [1:0] rf_rdata;                             // [0] = rs1, [1] = rs2
   logic           exe_valid;
   reg_addr_t      exe_rd;
   word_t          exe_data;
   logic           wb_we;
   reg_addr_t      wb_addr;
   word_t          wb_data;

   issue_ctrl issue_ctrl_i (
      .CLK       (CLK),
      .RST       (RST),
      .in_valid  (in_valid),
      .in_rd     (in_rd),
      .in_rs1    (in_rs1),
      .in_rs2    (in_rs2),
      .in_ready  (in_ready),
      .res_valid (res_valid),
      .res_ready (res_ready),
      .res_rd    (res_rd),
      .accept    (accept),
      .advance   (advance)
   );

   reg_file_nwnr #(
      .NUM_READ  (2),
      .NUM_WRITE (2)
   ) reg_file_i (
      .CLK   (CLK),
      .RST   (RST),
      .re    ({accept, accept}),
      .raddr ({in_rs2, in_rs1}),
      .rdata (rf_rdata),
      .we    ({host_we, wb_we}),                         // host on port 1 wins
      .waddr ({host_addr, wb_addr}),
      .wdata ({host_data, wb_data})
   );

   alu_stage alu_stage_i (
      .CLK       (CLK),
      .RST       (RST),
      .accept    (accept),
      .advance   (advance),
      .in_op     (in_op),
      .in_rd     (in_rd),
      .in_imm    (in_imm),
      .src1      (rf_rdata[0]),
      .src2      (rf_rdata[1]),
      .exe_valid (exe_valid),
      .exe_rd    (exe_rd),
      .exe_data  (exe_data)
   );

   result_stage result_stage_i (
      .CLK       (CLK),
      .RST       (RST),
      .advance   (advance),
      .exe_valid (exe_valid),
      .exe_rd    (exe_rd),
      .exe_data  (exe_data),
      .res_valid (res_valid),
      .res_ready (res_ready),
      .res_rd    (res_rd),
      .res_data  (res_data),
      .wb_we     (wb_we),
      .wb_addr   (wb_addr),
      .wb_data   (wb_data)
   );

endmodule

/* verilog/result_stage.sv */
`timescale 1ns/1ns

module result_stage (
   input  logic                CLK,
   input  logic                RST,
   input  logic                advance,                  // low only while blocked here
   input  logic                exe_valid,
   input  core_pkg::reg_addr_t exe_rd,
   input  core_pkg::word_t     exe_data,
   output logic                res_valid,
   input  logic                res_ready,
   output core_pkg::reg_addr_t res_rd,
   output core_pkg::word_t     res_data,
   output logic                wb_we,                    // rf write port 0
   output core_pkg::reg_addr_t wb_addr,
   output core_pkg::word_t     wb_data
);

   always_ff @(posedge CLK or negedge RST) begin
      if (!RST) begin
         res_valid <= 1'b0;
      end else if (advance) begin
         res_valid <= exe_valid;                         // empty or taken, refill
      end
   end

   // payload holds under back-pressure
   always_ff @(posedge CLK) begin
      if (advance && exe_valid) begin
         res_rd   <= exe_rd;
         res_data <= exe_data;
      end
   end

   // commit to the rf at the same edge the result leaves
   assign wb_we   = res_valid && res_ready;
   assign wb_addr = res_rd;
   assign wb_data = res_data;

endmodule

/* verilog/alu_stage.sv */
`timescale 1ns/1ns

module alu_stage (
   input  logic                CLK,
   input  logic                RST,
   input  logic                accept,                   // new instruction this edge
   input  logic                advance,
   input  core_pkg::alu_op_t   in_op,
   input  core_pkg::reg_addr_t in_rd,
   input  core_pkg::imm_t      in_imm,
   input  core_pkg::word_t     src1,                     // registered rf read data
   input  core_pkg::word_t     src2,
   output logic                exe_valid,
   output core_pkg::reg_addr_t exe_rd,
   output core_pkg::word_t     exe_data
);
   import core_pkg::*;

   logic      rd_valid;                                  // read stage occupied
   alu_op_t   op_q;
   reg_addr_t rd_q;
   imm_t      imm_q;
   word_t     imm_ext;                                   // sign-extended immediate
   logic [4:0] shamt;                                    // low five bits of src2

   // valid flag, in step with the rf read latency
   always_ff @(posedge CLK or negedge RST) begin
      if (!RST) begin
         rd_valid <= 1'b0;
      end else if (advance) begin
         rd_valid <= accept;                             // bubble if nothing accepted
      end
   end

   // payload, moves with the pipe
   always_ff @(posedge CLK) begin
      if (advance) begin
         op_q  <= in_op;
         rd_q  <= in_rd;
         imm_q <= in_imm;
      end
   end

   assign imm_ext = {{(DATA_W-IMM_W){imm_q[IMM_W-1]}}, imm_q};
   assign shamt   = src2[4:0];

   always_comb begin
      case (op_q)
         OP_ADD:  exe_data = src1 + src2;
         OP_SUB:  exe_data = src1 - src2;
         OP_AND:  exe_data = src1 & src2;
         OP_OR:   exe_data = src1 | src2;
         OP_XOR:  exe_data = src1 ^ src2;
         OP_SLL:  exe_data = src1 << shamt;              // upper src2 bits ignored
         OP_SRL:  exe_data = src1 >> shamt;              // zero fill
         OP_ADDI: exe_data = src1 + imm_ext;             // src2 unused
         default: exe_data = '0;
      endcase
   end

   assign exe_valid = rd_valid;
   assign exe_rd    = rd_q;

endmodule

/* verilog/issue_ctrl.sv */
`timescale 1ns/1ns

module issue_ctrl (
   input  logic                CLK,
   input  logic                RST,
   input  logic                in_valid,
   input  core_pkg::reg_addr_t in_rd,
   input  core_pkg::reg_addr_t in_rs1,
   input  core_pkg::reg_addr_t in_rs2,
   output logic                in_ready,
   input  logic                res_valid,
   input  logic                res_ready,
   input  core_pkg::reg_addr_t res_rd,
   output logic                accept,                   // transfer, doubles as rf read enable
   output logic                advance                   // whole pipe moves
);
   import core_pkg::*;

   logic [NUM_REGS-1:0] pending;                         // one bit per reg with a write in flight
   logic                run;                             // low until first edge after reset
   logic                hazard;                          // instruction touches a pending reg
   logic                res_xfer;                        // result leaves this cycle

   // stall everything only when the result register is full and blocked
   assign advance  = !(res_valid && !res_ready);
   assign res_xfer = res_valid && res_ready;

   // raw, war and waw all collapse onto the same pending check
   assign hazard = pending[in_rd] || pending[in_rs1] || pending[in_rs2];

   assign in_ready = run && advance && !hazard;
   assign accept   = in_valid && in_ready;

   always_ff @(posedge CLK or negedge RST) begin
      if (!RST) begin
         run <= 1'b0;
      end else begin
         run <= 1'b1;                                    // in_ready held low through reset
      end
   end

   // scoreboard
   always_ff @(posedge CLK or negedge RST) begin
      if (!RST) begin
         pending <= '0;
      end else begin
         if (res_xfer) begin
            pending[res_rd] <= 1'b0;                     // writeback commits at this edge
         end
         if (accept) begin
            pending[in_rd] <= 1'b1;                      // never the reg being released
         end
      end
   end

endmodule

/* verilog/reg_file_nwnr.sv */
`timescale 1ns/1ns

module reg_file_nwnr #(
   parameter int NUM_READ  = 2,                          // registered read ports
   parameter int NUM_WRITE = 2                           // write ports, highest index wins
) (
   input  logic                                CLK,
   input  logic                                RST,
   input  logic [NUM_READ-1:0]                 re,       // per-port read enable
   input  core_pkg::reg_addr_t [NUM_READ-1:0]  raddr,
   output core_pkg::word_t     [NUM_READ-1:0]  rdata,    // holds while re low
   input  logic [NUM_WRITE-1:0]                we,
   input  core_pkg::reg_addr_t [NUM_WRITE-1:0] waddr,
   input  core_pkg::word_t     [NUM_WRITE-1:0] wdata
);
   import core_pkg::*;

   word_t regs [NUM_REGS];                               // the storage array

   // storage, reset to the per-register vector
   always_ff @(posedge CLK or negedge RST) begin
      if (!RST) begin
         for (int j = 0; j < NUM_REGS; j++) begin
            regs[j] <= RF_RST_VECTOR[j*DATA_W +: DATA_W]; // word j of the packed vector
         end
      end else begin
         for (int j = 0; j < NUM_WRITE; j++) begin       // later port overrides earlier
            if (we[j]) begin
               regs[waddr[j]] <= wdata[j];               // lands at this edge
            end
         end
      end
   end

   // read output registers, one per port
   always_ff @(posedge CLK or negedge RST) begin
      if (!RST) begin
         rdata <= '0;
      end else begin
         for (int i = 0; i < NUM_READ; i++) begin
            if (re[i]) begin
               rdata[i] <= regs[raddr[i]];               // old value on same-edge write
            end
         end
      end
   end

endmodule

/* verilog/core_pkg.sv */
package core_pkg;

   localparam int DATA_W   = 32;                        // register and result width
   localparam int REG_AW   = 4;                         // register address width
   localparam int NUM_REGS = 16;                        // 1 << REG_AW
   localparam int IMM_W    = 16;                        // immediate field width

   typedef logic [DATA_W-1:0]        word_t;            // register value / result
   typedef logic [REG_AW-1:0]        reg_addr_t;        // register number
   typedef logic signed [IMM_W-1:0]  imm_t;             // sign-extended at use

   typedef enum logic [2:0] {
      OP_ADD  = 3'd0,                                   // rs1 + rs2
      OP_SUB  = 3'd1,                                   // rs1 - rs2
      OP_AND  = 3'd2,
      OP_OR   = 3'd3,
      OP_XOR  = 3'd4,
      OP_SLL  = 3'd5,                                   // shamt = rs2[4:0]
      OP_SRL  = 3'd6,                                   // logical, same shamt rule
      OP_ADDI = 3'd7                                    // rs1 + sext(imm)
   } alu_op_t;

   // register i comes out of reset as byte i in every byte lane
   function automatic logic [NUM_REGS*DATA_W-1:0] rf_rst_vector_f();
      logic [NUM_REGS*DATA_W-1:0] v;
      v = '0;
      for (int i = 0; i < NUM_REGS; i++) begin
         v[i*DATA_W +: DATA_W] = {(DATA_W/8){8'(i)}};  // e.g. reg 3 -> 32'h03030303
      end
      return v;
   endfunction

   localparam logic [NUM_REGS*DATA_W-1:0] RF_RST_VECTOR = rf_rst_vector_f(); // packed, reg 0 at lsb

endpackage
